// File: Makefile
TOP = tb_st_shifter

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f st_shifter_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f st_shifter_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "all tests passed" > /dev/null

clean:
	rm -rf obj_dir

// File: bench/st_shifter_checker.sv
// bound to st_shifter_top; sync widths and periods are checked only after the first full pulse
`timescale 1ns/1ps
`default_nettype none

module st_shifter_checker import shifter_pkg::*; (
	input logic       clk,
	input logic       reg_reset,
	input logic       hs,
	input logic       vs,
	input logic       read,
	input logic [5:0] video_r,
	input logic [5:0] video_g,
	input logic [5:0] video_b
);

	logic        hs_q;
	logic        vs_q;
	logic        hs_seen;
	logic        vs_seen;
	logic [9:0]  hs_len;
	logic [9:0]  hs_per;
	logic [11:0] vs_len;
	logic [18:0] vs_per;
	// read by the testbench monitor
	int unsigned fail_cnt = 0;

	// --------------------------------------------------
	// pulse length and period counters
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			hs_q    <= 1'b0;
			vs_q    <= 1'b0;
			hs_seen <= 1'b0;
			vs_seen <= 1'b0;
			hs_len  <= '0;
			hs_per  <= '0;
			vs_len  <= '0;
			vs_per  <= '0;
		end else begin
			hs_q   <= hs;
			vs_q   <= vs;
			hs_len <= hs ? hs_len + 10'd1 : '0;
			vs_len <= vs ? vs_len + 12'd1 : '0;
			// clocks since the last rising edge
			hs_per <= (hs && !hs_q) ? 10'd1 : hs_per + 10'd1;
			vs_per <= (vs && !vs_q) ? 19'd1 : vs_per + 19'd1;
			if (hs && !hs_q)
				hs_seen <= 1'b1;
			if (vs && !vs_q)
				vs_seen <= 1'b1;
		end
	end

	// --------------------------------------------------
	// 96 clocks high, 800 clock line
	hs_width: assert property (@(posedge clk) disable iff (reg_reset)
		(hs_q && !hs) |-> (hs_len == 10'd96))
		else begin $error("hs width %0d", hs_len); fail_cnt++; end

	hs_period: assert property (@(posedge clk) disable iff (reg_reset)
		(hs && !hs_q && hs_seen) |-> (hs_per == 10'd800))
		else begin $error("hs period %0d", hs_per); fail_cnt++; end

	// 4 lines high, 440 line frame
	vs_width: assert property (@(posedge clk) disable iff (reg_reset)
		(vs_q && !vs) |-> (vs_len == 12'd3200))
		else begin $error("vs width %0d", vs_len); fail_cnt++; end

	vs_period: assert property (@(posedge clk) disable iff (reg_reset)
		(vs && !vs_q && vs_seen) |-> (vs_per == 19'd352000))
		else begin $error("vs period %0d", vs_per); fail_cnt++; end

	// both syncs lie inside blank
	sync_blank: assert property (@(posedge clk) disable iff (reg_reset)
		(hs || vs) |-> ({video_r, video_g, video_b} == '0))
		else begin $error("rgb not zero during sync"); fail_cnt++; end

	// at most one read per 4 clock subgroup, never during vertical sync
	read_spacing: assert property (@(posedge clk) disable iff (reg_reset)
		read |-> !($past(read) || $past(read, 2) || $past(read, 3)))
		else begin $error("reads closer than 4 clocks"); fail_cnt++; end

	read_vsync: assert property (@(posedge clk) disable iff (reg_reset)
		read |-> !vs)
		else begin $error("read during vsync"); fail_cnt++; end

endmodule

`default_nettype wire

// File: bench/tb_st_shifter.sv
// runs one mono and one low frame; checks start at the first vs fall after reset
`timescale 1ns/1ps
`default_nettype none

module tb_st_shifter import shifter_pkg::*; ();

	logic              clk;
	logic              reg_reset;
	logic              reg_sel;
	logic              reg_rw;
	logic              reg_uds;
	logic              reg_lds;
	logic [5:0]        reg_addr;
	cpu_word_u         reg_din;
	cpu_word_u         reg_dout;
	logic [ADDR_W-1:0] vaddr;
	logic              read;
	logic [DATA_W-1:0] data;
	logic              hs;
	logic              vs;
	logic [5:0]        video_r;
	logic [5:0]        video_g;
	logic [5:0]        video_b;

	// reference model state
	logic [31:0]       salt;
	logic [ADDR_W-1:0] base_exp;
	logic              mono_mode;
	logic [8:0]        pal_m [16];

	// monitor state
	logic valid;
	logic prev_hs;
	logic prev_vs;
	int   cyc;
	int   line_cur;
	int   rcount;
	int   line_reads;

	st_shifter_top i_dut (
		.clk       (clk),
		.reg_reset (reg_reset),
		.reg_sel   (reg_sel),
		.reg_rw    (reg_rw),
		.reg_uds   (reg_uds),
		.reg_lds   (reg_lds),
		.reg_addr  (reg_addr),
		.reg_din   (reg_din),
		.reg_dout  (reg_dout),
		.vaddr     (vaddr),
		.read      (read),
		.data      (data),
		.hs        (hs),
		.vs        (vs),
		.video_r   (video_r),
		.video_g   (video_g),
		.video_b   (video_b)
	);

	bind st_shifter_top st_shifter_checker i_check (
		.clk       (clk),
		.reg_reset (reg_reset),
		.hs        (hs),
		.vs        (vs),
		.read      (read),
		.video_r   (video_r),
		.video_g   (video_g),
		.video_b   (video_b)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// --------------------------------------------------
	// helpers
	task automatic report_failure(input string msg);
		$display("error at %0t: %s", $time, msg);
		$display("tests failed");
		$fatal(1, "stopped at first error");
	endtask

	// plane word stored at a word address, salted per run
	function automatic logic [15:0] word_at(input logic [ADDR_W-1:0] a);
		logic [31:0] x;
		x = {9'd0, a} ^ salt;
		return (x[15:0] * 16'h9e37) ^ x[31:16] ^ {x[7:0], x[15:8]};
	endfunction

	function automatic logic [17:0] widen(input logic [8:0] c);
		return {{2{c[8:6]}}, {2{c[5:3]}}, {2{c[2:0]}}};
	endfunction

	// pixel i of display line n from the memory contents
	function automatic logic [17:0] pixel_expected(input int n, input int i);
		int         grp;
		int         bitpos;
		logic [3:0] idx;
		logic [15:0] w;
		grp    = n * 40 + i / 16;
		bitpos = 15 - (i % 16);
		if (mono_mode) begin
			w = word_at(base_exp + ADDR_W'(grp));
			return {18{w[bitpos] ^ pal_m[0][0]}};
		end
		// low mode, planes at consecutive words
		for (int p = 0; p < 4; p++) begin
			w = word_at(base_exp + ADDR_W'(grp * 4 + p));
			idx[p] = w[bitpos];
		end
		return widen(pal_m[idx]);
	endfunction

	task automatic write_reg(input logic [5:0] a, input logic [15:0] d,
		input logic uds_n, input logic lds_n);
		@(posedge clk);
		#1;
		reg_sel  = 1'b1;
		reg_rw   = 1'b0;
		reg_addr = a;
		reg_din  = d;
		reg_uds  = uds_n;
		reg_lds  = lds_n;
		@(posedge clk);
		#1;
		reg_sel = 1'b0;
		reg_rw  = 1'b1;
		reg_uds = 1'b1;
		reg_lds = 1'b1;
	endtask

	task automatic check_read(input logic [5:0] a, input logic [15:0] want, input string what);
		logic [15:0] d;
		@(posedge clk);
		#1;
		reg_sel  = 1'b1;
		reg_rw   = 1'b1;
		reg_addr = a;
		@(negedge clk);
		d = reg_dout;
		@(posedge clk);
		#1;
		reg_sel = 1'b0;
		assert (d == want)
			else report_failure($sformatf("%s read 0x%04h, expected 0x%04h", what, d, want));
	endtask

	// one frame is 352000 clocks
	task automatic wait_vs_fall(input string what);
		logic last;
		logic found;
		last  = vs;
		found = 1'b0;
		for (int n = 0; n < 360000 && !found; n++) begin
			@(negedge clk);
			if (last && !vs)
				found = 1'b1;
			last = vs;
		end
		if (!found)
			report_failure({"timed out waiting for vs to fall ", what});
	endtask

	// --------------------------------------------------
	// memory, answers the 4 word block around vaddr
	always @(posedge clk) begin
		#1;
		if (read)
			data = {word_at({vaddr[22:2], 2'd3}), word_at({vaddr[22:2], 2'd2}),
				word_at({vaddr[22:2], 2'd1}), word_at({vaddr[22:2], 2'd0})};
	end

	// --------------------------------------------------
	// output monitor, position taken from hs and vs
	always @(negedge clk) begin
		logic [17:0] rgb;
		logic [17:0] want;
		int          h;
		if (reg_reset) begin
			valid      = 1'b0;
			prev_hs    = 1'b0;
			prev_vs    = 1'b0;
			cyc        = 0;
			line_cur   = 0;
			rcount     = 0;
			line_reads = 0;
		end else begin
			rgb = {video_r, video_g, video_b};
			if (prev_hs && !hs) begin
				// line that just ended its sync
				if (valid)
					assert (line_reads == ((line_cur < 400) ? (mono_mode ? 40 : 160) : 0))
						else report_failure($sformatf("%0d reads on line %0d",
							line_reads, line_cur));
				line_reads = 0;
				cyc        = 0;
			end else begin
				cyc++;
			end
			// pixel 0 of the next line
			if (cyc == 32)
				line_cur = (line_cur + 1) % 440;
			if (prev_vs && !vs) begin
				valid      = 1'b1;
				line_cur   = 424;
				rcount     = 0;
				line_reads = 0;
				assert (vaddr == base_exp)
					else report_failure($sformatf("vaddr 0x%06h after reload, expected 0x%06h",
						vaddr, base_exp));
			end
			if (valid) begin
				h = (cyc < 32) ? 768 + cyc : cyc - 32;
				if ((h >= 656 && h < 784) || (line_cur >= 410 && line_cur < 430))
					want = '0;
				else if (h < 640 && line_cur < 400)
					want = pixel_expected(line_cur, h);
				else
					want = widen(pal_m[0]);
				assert (rgb == want)
					else report_failure($sformatf("rgb 0x%05h at line %0d pixel %0d, expected 0x%05h",
						rgb, line_cur, h, want));
				if (line_cur < 400)
					assert (vaddr == base_exp + ADDR_W'(rcount))
						else report_failure($sformatf("vaddr 0x%06h, expected 0x%06h",
							vaddr, base_exp + ADDR_W'(rcount)));
			end
			if (read) begin
				rcount++;
				line_reads++;
			end
			prev_hs = hs;
			prev_vs = vs;
			if (i_dut.i_check.fail_cnt != 0)
				report_failure("a bound sync or fetch assertion failed");
		end
	end

	// --------------------------------------------------
	// stimulus
	initial begin
		logic [15:0] pal_word;
		logic [7:0]  base_hi;
		logic [7:0]  base_mid;
		void'($urandom(32'hb5415727));
		reg_reset = 1'b1;
		reg_sel   = 1'b0;
		reg_rw    = 1'b1;
		reg_uds   = 1'b1;
		reg_lds   = 1'b1;
		reg_addr  = '0;
		reg_din   = '0;
		data      = '0;
		mono_mode = 1'b1;
		salt      = $urandom();
		base_hi   = 8'($urandom());
		base_mid  = 8'($urandom());
		repeat (5) @(posedge clk);
		#1;
		reg_reset = 1'b0;

		// mid then hi, the low bits end up zero
		write_reg(REG_BASE_MID, {8'hff, base_mid}, 1'b1, 1'b0);
		write_reg(REG_BASE_HI, {8'hff, base_hi}, 1'b1, 1'b0);
		base_exp = {base_hi, base_mid, 7'd0};
		check_read(REG_BASE_HI, {8'h00, base_hi}, "base hi");
		check_read(REG_BASE_MID, {8'h00, base_mid}, "base mid");
		write_reg(REG_SYNC, 16'h02ff, 1'b0, 1'b1);
		check_read(REG_SYNC, 16'h0200, "sync mode");
		// mono is the reset mode, so leave it once first
		write_reg(REG_SHIFT_MODE, {6'd0, MODE_MID, 8'h00}, 1'b0, 1'b1);
		check_read(REG_SHIFT_MODE, {6'd0, MODE_MID, 8'h00}, "shift mode mid");
		write_reg(REG_SHIFT_MODE, {6'd0, MODE_MONO, 8'h00}, 1'b0, 1'b1);
		check_read(REG_SHIFT_MODE, {6'd0, MODE_MONO, 8'h00}, "shift mode mono");

		// palette, 3 bits kept per gun
		for (int i = 0; i < 16; i++) begin
			pal_word = 16'($urandom());
			write_reg(REG_PALETTE + 6'(i), pal_word, 1'b0, 1'b0);
			pal_m[i] = {pal_word[10:8], pal_word[6:4], pal_word[2:0]};
			check_read(REG_PALETTE + 6'(i), pal_word & 16'h0777, "palette");
		end

		wait_vs_fall("before the mono frame");
		wait_vs_fall("after the mono frame");
		// still in vertical blank here
		write_reg(REG_SHIFT_MODE, {6'd0, MODE_LOW, 8'h00}, 1'b0, 1'b1);
		mono_mode = 1'b0;
		check_read(REG_SHIFT_MODE, {6'd0, MODE_LOW, 8'h00}, "shift mode low");
		wait_vs_fall("after the low frame");

		if (i_dut.i_check.fail_cnt != 0) begin
			report_failure("a bound sync or fetch assertion failed");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cpu_registers.sv
// ST register subset only: no STE registers, reads are combinational and unqualified by strobes
`timescale 1ns/1ps
`default_nettype none

module cpu_registers import shifter_pkg::*; (
	input  logic              clk,
	input  logic              reg_reset,
	input  logic              reg_sel,
	input  logic              reg_rw,
	input  logic              reg_uds,
	input  logic              reg_lds,
	input  logic [5:0]        reg_addr,
	input  cpu_word_u         reg_din,
	input  logic [ADDR_W-1:0] vaddr,
	output cpu_word_u         reg_dout,
	output logic [ADDR_W-1:0] base_addr,
	output logic              mono,
	output logic [2:0]        plane_cnt,
	output logic [8:0]        palette [16]
);

	logic [1:0] shmode;
	logic [1:0] syncmode;
	logic       pal_hit;
	logic       wr;
	logic [3:0] pal_idx;

	assign wr      = reg_sel && !reg_rw;
	assign pal_hit = (reg_addr[5:4] == REG_PALETTE[5:4]);
	assign pal_idx = reg_addr[3:0];

	// --------------------------------------------------
	// writes, strobes are active low
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			base_addr <= BASE_ADDR_RESET;
			shmode    <= MODE_MONO;
			syncmode  <= 2'b00;
			for (int i = 0; i < 16; i++)
				palette[i] <= '0;
			// white background, blue lsb also inverts mono
			palette[0] <= 9'b000_000_111;
		end else if (wr) begin
			if (!reg_lds) begin
				if (reg_addr == REG_BASE_HI)
					base_addr[22:15] <= reg_din.bytes.lo;
				if (reg_addr == REG_BASE_MID)
					base_addr[14:7] <= reg_din.bytes.lo;
				// either base byte clears the low part
				if (reg_addr == REG_BASE_HI || reg_addr == REG_BASE_MID)
					base_addr[6:0] <= '0;
			end
			if (!reg_uds) begin
				if (reg_addr == REG_SYNC)
					syncmode <= reg_din.bytes.hi[1:0];
				if (reg_addr == REG_SHIFT_MODE)
					shmode <= reg_din.bytes.hi[1:0];
			end
			// red in the upper byte, green and blue in the lower
			if (pal_hit) begin
				if (!reg_uds)
					palette[pal_idx][8:6] <= reg_din.colour.r[2:0];
				if (!reg_lds) begin
					palette[pal_idx][5:3] <= reg_din.colour.g[2:0];
					palette[pal_idx][2:0] <= reg_din.colour.b[2:0];
				end
			end
		end
	end

	// --------------------------------------------------
	// reads
	always_comb begin
		reg_dout = '0;
		if (reg_sel && reg_rw) begin
			case (reg_addr)
				REG_BASE_HI:    reg_dout.bytes.lo = base_addr[22:15];
				REG_BASE_MID:   reg_dout.bytes.lo = base_addr[14:7];
				REG_VADDR_HI:   reg_dout.bytes.lo = vaddr[22:15];
				REG_VADDR_MID:  reg_dout.bytes.lo = vaddr[14:7];
				// byte address, bit 0 always zero
				REG_VADDR_LO:   reg_dout.bytes.lo = {vaddr[6:0], 1'b0};
				REG_SYNC:       reg_dout.bytes.hi = {6'b0, syncmode};
				REG_SHIFT_MODE: reg_dout.bytes.hi = {6'b0, shmode};
				default: begin
					if (pal_hit) begin
						reg_dout.colour.r = {1'b0, palette[pal_idx][8:6]};
						reg_dout.colour.g = {1'b0, palette[pal_idx][5:3]};
						reg_dout.colour.b = {1'b0, palette[pal_idx][2:0]};
					end
				end
			endcase
		end
	end

	// planes per 16 pixel group
	assign mono = (shmode == MODE_MONO);
	always_comb begin
		case (shmode)
			MODE_MONO: plane_cnt = 3'd1;
			MODE_MID:  plane_cnt = 3'd2;
			MODE_LOW:  plane_cnt = 3'd4;
			default:   plane_cnt = 3'd4;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/fetch_control.sv
// memory must answer within the read clock and hold data; no wait states are supported
`timescale 1ns/1ps
`default_nettype none

module fetch_control import shifter_pkg::*; (
	input  logic               clk,
	input  logic               reg_reset,
	video_timing_if.sink       tim,
	input  logic [ADDR_W-1:0]  base_addr,
	input  logic [2:0]         plane_cnt,
	input  logic [DATA_W-1:0]  data,
	output logic               read,
	output logic [ADDR_W-1:0]  vaddr,
	output logic [PLANE_W-1:0] plane_word,
	output logic               plane_load,
	output logic               group_done,
	output logic [1:0]         plane_sel
);

	logic [1:0]         state;
	logic [1:0]         plane;
	logic               grp_pend;
	logic               win_next;
	logic [1:0]         sub_next;
	logic [PLANE_W-1:0] lane;

	// --------------------------------------------------
	// look one clock ahead so the request lands on slot 0
	// a new line enters the window after the last line or below line 399
	assign win_next = (tim.hcnt == H_TOTAL - 10'd1) ?
		((tim.vcnt == V_TOTAL - 10'd1) || (tim.vcnt < V_DISP - 10'd1)) :
		(tim.fetch_win && (tim.hcnt != H_DISP - 10'd1));
	// subgroup of the next clock, one plane per subgroup
	assign sub_next = tim.hcnt[3:2] + 2'd1;

	assign read       = (state == FS_REQ);
	assign plane_load = (state == FS_CAP);
	assign plane_sel  = plane;
	// shift registers reload as the next group starts
	assign group_done = grp_pend && (tim.hcnt[3:0] == 4'hf);

	// only 16 of the 64 bits carry the word at vaddr
	assign lane = data[vaddr[1:0] * PLANE_W +: PLANE_W];

	always_ff @(posedge clk) begin
		if (reg_reset) begin
			state    <= FS_IDLE;
			plane    <= '0;
			grp_pend <= 1'b0;
		end else begin
			case (state)
				FS_IDLE: begin
					if (tim.slot == 2'd3 && win_next && {1'b0, sub_next} < plane_cnt)
						state <= FS_REQ;
				end
				FS_REQ:  state <= FS_CAP;
				default: state <= FS_IDLE;
			endcase

			if (group_done)
				grp_pend <= 1'b0;

			// step planes, last one arms the group reload
			if (state == FS_CAP) begin
				if ({1'b0, plane} == plane_cnt - 3'd1) begin
					plane    <= '0;
					grp_pend <= 1'b1;
				end else begin
					plane <= plane + 2'd1;
				end
			end else if (!tim.fetch_win) begin
				plane <= '0;
			end
		end
	end

	// --------------------------------------------------
	// video address counter, reloaded once per frame after vsync
	always_ff @(posedge clk) begin
		if (reg_reset)
			vaddr <= BASE_ADDR_RESET;
		else if (tim.hcnt == '0 && tim.vcnt == V_SYNC)
			vaddr <= base_addr;
		else if (state == FS_REQ)
			vaddr <= vaddr + 23'd1;
	end

	// sample the memory word on the edge that ends the read
	always_ff @(posedge clk) begin
		if (state == FS_REQ)
			plane_word <= lane;
	end

endmodule

`default_nettype wire

// File: rtl/pixel_shifter.sv
// output delay is fixed at PIXEL_LAG clocks; mode and palette changes apply with no delay
`timescale 1ns/1ps
`default_nettype none

module pixel_shifter import shifter_pkg::*; (
	input  logic               clk,
	input  logic               reg_reset,
	video_timing_if.sink       tim,
	input  logic [PLANE_W-1:0] plane_word,
	input  logic               plane_load,
	input  logic [1:0]         plane_sel,
	input  logic               group_done,
	input  logic [8:0]         palette [16],
	input  logic               mono,
	input  logic [2:0]         plane_cnt,
	output logic [5:0]         video_r,
	output logic [5:0]         video_g,
	output logic [5:0]         video_b,
	output logic               hs,
	output logic               vs
);

	logic [PLANE_W-1:0] latch [4];
	logic [PLANE_W-1:0] shift [4];
	logic [3:0]         idx;
	logic               mono_bit;
	// per stage: blank, border, display, hs, vs
	logic [PIXEL_LAG-3:0][4:0] flag_d;
	logic [4:0]         flag_px;
	logic [8:0]         s1_col;
	logic               s1_level;
	logic               s1_mono;
	logic               s1_blank;
	logic               s1_hs;
	logic               s1_vs;

	// --------------------------------------------------
	// plane latches and shift registers
	always_ff @(posedge clk) begin
		if (plane_load)
			latch[plane_sel] <= plane_word;
	end

	always_ff @(posedge clk) begin
		for (int p = 0; p < 4; p++) begin
			if (group_done)
				shift[p] <= latch[p];
			else
				shift[p] <= {shift[p][PLANE_W-2:0], 1'b0};
		end
	end

	// unused planes may hold words of an earlier mode
	assign idx = {shift[3][PLANE_W-1] & (plane_cnt > 3'd2),
		shift[2][PLANE_W-1] & (plane_cnt > 3'd2),
		shift[1][PLANE_W-1] & (plane_cnt > 3'd1),
		shift[0][PLANE_W-1]};
	// mono: blue lsb of entry 0 inverts the picture
	assign mono_bit = shift[0][PLANE_W-1] ^ palette[0][0];

	// --------------------------------------------------
	// flags follow the 16 clock prefetch
	assign flag_px = flag_d[PIXEL_LAG-3];

	always_ff @(posedge clk) begin
		if (reg_reset) begin
			// matches the border position the timer resets to
			flag_d   <= {(PIXEL_LAG-2){5'b01000}};
			s1_mono  <= 1'b0;
			s1_blank <= 1'b0;
			s1_hs    <= 1'b0;
			s1_vs    <= 1'b0;
		end else begin
			flag_d   <= {flag_d[PIXEL_LAG-4:0],
				{tim.blank, tim.border, tim.display, tim.hs_raw, tim.vs_raw}};
			s1_mono  <= mono && flag_px[2];
			s1_blank <= flag_px[4];
			s1_hs    <= flag_px[1];
			s1_vs    <= flag_px[0];
		end
	end

	// stage 1, palette lookup; border shows entry 0
	always_ff @(posedge clk) begin
		s1_col   <= flag_px[3] ? palette[0] : palette[idx];
		s1_level <= mono_bit;
	end

	// --------------------------------------------------
	// stage 2, output registers
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			video_r <= '0;
			video_g <= '0;
			video_b <= '0;
			hs      <= 1'b0;
			vs      <= 1'b0;
		end else begin
			hs <= s1_hs;
			vs <= s1_vs;
			if (s1_blank) begin
				video_r <= '0;
				video_g <= '0;
				video_b <= '0;
			end else if (s1_mono) begin
				video_r <= {6{s1_level}};
				video_g <= {6{s1_level}};
				video_b <= {6{s1_level}};
			end else begin
				// 3 bit gun repeated to 6 bits
				video_r <= {2{s1_col[8:6]}};
				video_g <= {2{s1_col[5:3]}};
				video_b <= {2{s1_col[2:0]}};
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/shifter_pkg.sv
// one fixed 800x440 frame only; region constants mark where each region ends, not where it starts
`default_nettype none

package shifter_pkg;

	// --------------------------------------------------
	// widths
	localparam int ADDR_W  = 23;
	localparam int DATA_W  = 64;
	localparam int PLANE_W = 16;
	localparam int CNT_W   = 10;

	// --------------------------------------------------
	// horizontal timing, one clock per pixel
	// display 0..639, border, blank, sync, blank, left border up to 799
	localparam logic [CNT_W-1:0] H_DISP     = 10'd640;
	localparam logic [CNT_W-1:0] H_BORDER_R = 10'd656;
	localparam logic [CNT_W-1:0] H_BLANK_R  = 10'd672;
	localparam logic [CNT_W-1:0] H_SYNC     = 10'd768;
	localparam logic [CNT_W-1:0] H_BLANK_L  = 10'd784;
	localparam logic [CNT_W-1:0] H_TOTAL    = 10'd800;

	// vertical timing in lines, same region order
	localparam logic [CNT_W-1:0] V_DISP     = 10'd400;
	localparam logic [CNT_W-1:0] V_BORDER_B = 10'd410;
	localparam logic [CNT_W-1:0] V_BLANK_B  = 10'd420;
	localparam logic [CNT_W-1:0] V_SYNC     = 10'd424;
	localparam logic [CNT_W-1:0] V_BLANK_T  = 10'd430;
	localparam logic [CNT_W-1:0] V_TOTAL    = 10'd440;

	// counter position to rgb pins: 16 clocks group prefetch + 2 output stages
	localparam int PIXEL_LAG = 18;

	// word address 0x8000 = byte address 0x010000
	localparam logic [ADDR_W-1:0] BASE_ADDR_RESET = 23'h008000;

	// shift mode codes as seen in bits 9:8 of the shift mode register
	localparam logic [1:0] MODE_LOW  = 2'd0;
	localparam logic [1:0] MODE_MID  = 2'd1;
	localparam logic [1:0] MODE_MONO = 2'd2;

	// --------------------------------------------------
	// register word addresses
	localparam logic [5:0] REG_BASE_HI    = 6'h00;
	localparam logic [5:0] REG_BASE_MID   = 6'h01;
	localparam logic [5:0] REG_VADDR_HI   = 6'h02;
	localparam logic [5:0] REG_VADDR_MID  = 6'h03;
	localparam logic [5:0] REG_VADDR_LO   = 6'h04;
	localparam logic [5:0] REG_SYNC       = 6'h05;
	localparam logic [5:0] REG_PALETTE    = 6'h20;
	localparam logic [5:0] REG_SHIFT_MODE = 6'h30;

	// fetch fsm states
	localparam logic [1:0] FS_IDLE = 2'd0;
	localparam logic [1:0] FS_REQ  = 2'd1;
	localparam logic [1:0] FS_CAP  = 2'd2;

	// cpu data word, palette view or byte view
	// top bit of each colour nibble is the STE lsb and is ignored here
	typedef union packed {
		struct packed {
			logic [3:0] unused;
			logic [3:0] r;
			logic [3:0] g;
			logic [3:0] b;
		} colour;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
	} cpu_word_u;

endpackage

`default_nettype wire

// File: rtl/st_shifter_top.sv
// single clock; register port and memory port share clk, syncs are active high
`timescale 1ns/1ps
`default_nettype none

module st_shifter_top import shifter_pkg::*; (
	input  logic              clk,
	input  logic              reg_reset,
	// cpu register port
	input  logic              reg_sel,
	input  logic              reg_rw,
	input  logic              reg_uds,
	input  logic              reg_lds,
	input  logic [5:0]        reg_addr,
	input  cpu_word_u         reg_din,
	output cpu_word_u         reg_dout,
	// video memory port
	output logic [ADDR_W-1:0] vaddr,
	output logic              read,
	input  logic [DATA_W-1:0] data,
	// video out
	output logic              hs,
	output logic              vs,
	output logic [5:0]        video_r,
	output logic [5:0]        video_g,
	output logic [5:0]        video_b
);

	logic [ADDR_W-1:0]  base_addr;
	logic [2:0]         plane_cnt;
	logic               mono;
	logic [8:0]         palette [16];
	logic [PLANE_W-1:0] plane_word;
	logic               plane_load;
	logic               group_done;
	logic [1:0]         plane_sel;

	video_timing_if tim_if ();

	video_timer i_timer (
		.clk       (clk),
		.reg_reset (reg_reset),
		.tim       (tim_if.timer)
	);

	fetch_control i_fetch (
		.clk        (clk),
		.reg_reset  (reg_reset),
		.tim        (tim_if.sink),
		.base_addr  (base_addr),
		.plane_cnt  (plane_cnt),
		.data       (data),
		.read       (read),
		.vaddr      (vaddr),
		.plane_word (plane_word),
		.plane_load (plane_load),
		.group_done (group_done),
		.plane_sel  (plane_sel)
	);

	cpu_registers i_regs (
		.clk       (clk),
		.reg_reset (reg_reset),
		.reg_sel   (reg_sel),
		.reg_rw    (reg_rw),
		.reg_uds   (reg_uds),
		.reg_lds   (reg_lds),
		.reg_addr  (reg_addr),
		.reg_din   (reg_din),
		.vaddr     (vaddr),
		.reg_dout  (reg_dout),
		.base_addr (base_addr),
		.mono      (mono),
		.plane_cnt (plane_cnt),
		.palette   (palette)
	);

	pixel_shifter i_shifter (
		.clk        (clk),
		.reg_reset  (reg_reset),
		.tim        (tim_if.sink),
		.plane_word (plane_word),
		.plane_load (plane_load),
		.plane_sel  (plane_sel),
		.group_done (group_done),
		.palette    (palette),
		.mono       (mono),
		.plane_cnt  (plane_cnt),
		.video_r    (video_r),
		.video_g    (video_g),
		.video_b    (video_b),
		.hs         (hs),
		.vs         (vs)
	);

endmodule

`default_nettype wire

// File: rtl/video_timer.sv
// no runtime timing selection; reset parks the counters on the last clock of the frame
`timescale 1ns/1ps
`default_nettype none

module video_timer import shifter_pkg::*; (
	input  logic         clk,
	input  logic         reg_reset,
	video_timing_if.timer tim
);

	logic [CNT_W-1:0] h_nxt;
	logic [CNT_W-1:0] v_nxt;
	logic             h_wrap;
	logic             h_disp;
	logic             v_disp;
	logic             h_blank;
	logic             v_blank;

	// --------------------------------------------------
	// next counter position
	assign h_wrap = (tim.hcnt == H_TOTAL - 10'd1);
	assign h_nxt  = h_wrap ? '0 : tim.hcnt + 10'd1;

	// line advances at the end of each line
	always_comb begin
		v_nxt = tim.vcnt;
		if (h_wrap)
			v_nxt = (tim.vcnt == V_TOTAL - 10'd1) ? '0 : tim.vcnt + 10'd1;
	end

	// regions of the next position, registered below so they line up with the counters
	assign h_disp  = (h_nxt < H_DISP);
	assign v_disp  = (v_nxt < V_DISP);
	assign h_blank = (h_nxt >= H_BORDER_R) && (h_nxt < H_BLANK_L);
	assign v_blank = (v_nxt >= V_BORDER_B) && (v_nxt < V_BLANK_T);

	// --------------------------------------------------
	// counters and flags
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			// last position of the frame, left and top border
			tim.hcnt      <= H_TOTAL - 10'd1;
			tim.vcnt      <= V_TOTAL - 10'd1;
			tim.slot      <= 2'd3;
			tim.fetch_win <= 1'b0;
			tim.display   <= 1'b0;
			tim.border    <= 1'b1;
			tim.blank     <= 1'b0;
			tim.hs_raw    <= 1'b0;
			tim.vs_raw    <= 1'b0;
		end else begin
			tim.hcnt <= h_nxt;
			tim.vcnt <= v_nxt;
			// 800 is a multiple of 4 so slot stays locked to hcnt
			tim.slot <= tim.slot + 2'd1;

			tim.fetch_win <= h_disp && v_disp;
			tim.display   <= h_disp && v_disp;
			tim.blank     <= h_blank || v_blank;
			// border is whatever is neither picture nor blank
			tim.border    <= !(h_disp && v_disp) && !(h_blank || v_blank);

			// syncs sit inside the blank regions
			tim.hs_raw <= (h_nxt >= H_BLANK_R) && (h_nxt < H_SYNC);
			tim.vs_raw <= (v_nxt >= V_BLANK_B) && (v_nxt < V_SYNC);
		end
	end

endmodule

`default_nettype wire

// File: rtl/video_timing_if.sv
// all members are driven by video_timer only; flags describe the position in hcnt/vcnt
`timescale 1ns/1ps
`default_nettype none

interface video_timing_if import shifter_pkg::*; ();

	logic [CNT_W-1:0] hcnt;
	logic [CNT_W-1:0] vcnt;
	// clock within the 4 clock fetch subgroup, 0 at hcnt 0
	logic [1:0]       slot;
	logic             fetch_win;
	logic             border;
	logic             display;
	logic             blank;
	// raw syncs, not yet delayed to pixel position
	logic             hs_raw;
	logic             vs_raw;

	modport timer (
		output hcnt, vcnt, slot, fetch_win, border, display, blank, hs_raw, vs_raw
	);

	modport sink (
		input hcnt, vcnt, slot, fetch_win, border, display, blank, hs_raw, vs_raw
	);

endinterface

`default_nettype wire

// File: st_shifter_top.f
rtl/shifter_pkg.sv
rtl/video_timing_if.sv
rtl/video_timer.sv
rtl/fetch_control.sv
rtl/cpu_registers.sv
rtl/pixel_shifter.sv
rtl/st_shifter_top.sv
bench/st_shifter_checker.sv
bench/tb_st_shifter.sv
